//--- dcache_sub.f
rtl/dcache_pkg.sv
rtl/dcache_ram.sv
rtl/dcache_rport.sv
rtl/dcache_wport.sv
rtl/dcache_wb_master.sv
rtl/dcache_top.sv
test/wb_mem_model.sv
test/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache_sub

sources:
  - rtl/dcache_pkg.sv
  - rtl/dcache_ram.sv
  - rtl/dcache_rport.sv
  - rtl/dcache_wport.sv
  - rtl/dcache_wb_master.sv
  - rtl/dcache_top.sv
  - target: test
    files:
      - test/wb_mem_model.sv
      - test/tb_dcache.sv

//--- test/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
  import dcache_pkg::*;
();

  localparam int CLK_HALF      = 4;
  localparam int MEM_WORDS     = 1024;
  localparam int IDX_W         = $clog2(MEM_WORDS);
  localparam int MAX_ENTRIES   = 64;
  localparam int CYC_PER_ENTRY = 40;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  addr_t       req_addr;
  logic        req_write;
  ld_type_e    req_type;
  word_t       req_wdata;
  strobe_t     req_strobe;
  logic        req_uncached;
  word_t       rdata;
  logic        rvalid;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  addr_t       wb_adr;
  word_t       wb_dat_m2s;
  word_t       wb_dat_s2m;
  strobe_t     wb_sel;
  logic        wb_ack;
  logic [31:0] read_cnt;

  // stimulus table, one request per entry
  logic     tab_write    [MAX_ENTRIES];
  addr_t    tab_addr     [MAX_ENTRIES];
  ld_type_e tab_type     [MAX_ENTRIES];
  word_t    tab_wdata    [MAX_ENTRIES];
  strobe_t  tab_strobe   [MAX_ENTRIES];
  logic     tab_uncached [MAX_ENTRIES];
  word_t    tab_rdata    [MAX_ENTRIES];
  int       tab_reads    [MAX_ENTRIES];  // bus reads this entry adds
  logic     tab_burst    [MAX_ENTRIES];  // result due one cycle after the previous
  int       read_idx     [MAX_ENTRIES];

  word_t       ref_mem [MEM_WORDS];
  int          n_entries       = 0;
  int          n_reads         = 0;
  int          reads_so_far    = 0;
  int          resp_cnt        = 0;
  int          last_resp_cycle = 0;
  logic [31:0] last_read_cnt   = '0;  // bus read count at the previous result
  int          cycle_cnt       = 0;
  int          timeout_limit   = 1000;
  int          fail_cnt        = 0;

  dcache_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_addr_i     (req_addr),
    .req_write_i    (req_write),
    .req_type_i     (req_type),
    .req_wdata_i    (req_wdata),
    .req_strobe_i   (req_strobe),
    .req_uncached_i (req_uncached),
    .rdata_o        (rdata),
    .rvalid_o       (rvalid),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_we_o        (wb_we),
    .wb_adr_o       (wb_adr),
    .wb_dat_o       (wb_dat_m2s),
    .wb_sel_o       (wb_sel),
    .wb_dat_i       (wb_dat_s2m),
    .wb_ack_i       (wb_ack)
  );

  wb_mem_model #(
    .DEPTH     (MEM_WORDS),
    .ACK_DELAY (2)
  ) u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_m2s),
    .wb_sel_i   (wb_sel),
    .wb_dat_o   (wb_dat_s2m),
    .wb_ack_o   (wb_ack),
    .read_cnt_o (read_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      fail_cnt++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h (cycle %0d)",
               name, got, exp, cycle_cnt);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // pick the addressed lane, then extend it
  function automatic word_t format_expected(word_t word, logic [1:0] off, ld_type_e kind);
    logic [7:0]  lane;
    logic [15:0] half;
    lane = word[8*off +: 8];
    half = off[1] ? word[31:16] : word[15:0];
    case (kind)
      LD_B:    return {{24{lane[7]}}, lane};
      LD_BU:   return {24'h0, lane};
      LD_H:    return {{16{half[15]}}, half};
      LD_HU:   return {16'h0, half};
      default: return word;
    endcase
  endfunction

  task automatic init_reference();
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = 32'(i * 4) ^ 32'hA5A5_0000;
    end
  endtask

  task automatic load_entry(addr_t addr, ld_type_e kind, logic uncached, int reads,
                            logic burst);
    tab_write[n_entries]    = 1'b0;
    tab_addr[n_entries]     = addr;
    tab_type[n_entries]     = kind;
    tab_wdata[n_entries]    = '0;
    tab_strobe[n_entries]   = '0;
    tab_uncached[n_entries] = uncached;
    tab_rdata[n_entries]    = format_expected(ref_mem[addr[IDX_W+1:2]], addr[1:0], kind);
    tab_reads[n_entries]    = reads;
    tab_burst[n_entries]    = burst;
    reads_so_far += reads;
    read_idx[n_reads] = n_entries;
    n_reads++;
    n_entries++;
  endtask

  task automatic store_entry(addr_t addr, word_t wdata, strobe_t strobe);
    for (int b = 0; b < 4; b++) begin
      if (strobe[b]) ref_mem[addr[IDX_W+1:2]][8*b +: 8] = wdata[8*b +: 8];
    end
    tab_write[n_entries]    = 1'b1;
    tab_addr[n_entries]     = addr;
    tab_type[n_entries]     = LD_W;
    tab_wdata[n_entries]    = wdata;
    tab_strobe[n_entries]   = strobe;
    tab_uncached[n_entries] = 1'b0;
    tab_rdata[n_entries]    = '0;
    tab_reads[n_entries]    = 0;  // stores only write memory
    tab_burst[n_entries]    = 1'b0;
    n_entries++;
  endtask

  task automatic build_table();
    // cold miss, then a hit in the same line
    load_entry(32'h014, LD_W, 1'b0, 4, 1'b0);
    load_entry(32'h01C, LD_W, 1'b0, 0, 1'b0);
    // store hit right before a load of the same word
    load_entry(32'h028, LD_W, 1'b0, 4, 1'b0);
    store_entry(32'h028, 32'h1122_3344, 4'b0110);
    load_entry(32'h028, LD_W, 1'b0, 0, 1'b0);
    load_entry(32'h02A, LD_BU, 1'b0, 0, 1'b0);
    load_entry(32'h028, LD_W, 1'b1, 1, 1'b0);  // memory has the merged word
    // store miss does not allocate, the refill brings the new bytes
    store_entry(32'h0A0, 32'hCAFE_F00D, 4'b1001);
    load_entry(32'h0A0, LD_W, 1'b0, 4, 1'b0);
    // sub-word loads at every offset, word 0xa5a50080
    load_entry(32'h080, LD_W, 1'b0, 4, 1'b0);
    for (int off = 0; off < 4; off++) begin
      load_entry(addr_t'(32'h080 + off), LD_B, 1'b0, 0, 1'b0);
      load_entry(addr_t'(32'h080 + off), LD_BU, 1'b0, 0, 1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      load_entry(addr_t'(32'h080 + off), LD_H, 1'b0, 0, 1'b0);
      load_entry(addr_t'(32'h080 + off), LD_HU, 1'b0, 0, 1'b0);
    end
    // uncached reads bypass the cache even for cached lines
    load_entry(32'h014, LD_W, 1'b1, 1, 1'b0);
    load_entry(32'h304, LD_W, 1'b1, 1, 1'b0);
    load_entry(32'h304, LD_W, 1'b0, 4, 1'b0);
    load_entry(32'h306, LD_H, 1'b1, 1, 1'b0);
    // set 4 conflict, victim pointer toggles on every refill
    load_entry(32'h044, LD_W, 1'b0, 4, 1'b0);  // A
    load_entry(32'h148, LD_W, 1'b0, 4, 1'b0);  // B in the other way
    load_entry(32'h24C, LD_W, 1'b0, 4, 1'b0);  // C evicts A
    load_entry(32'h050, LD_W, 1'b0, 4, 1'b0);  // set 5 refill moves the pointer
    load_entry(32'h044, LD_W, 1'b0, 4, 1'b0);  // A again evicts C
    load_entry(32'h148, LD_W, 1'b0, 0, 1'b0);
    // back-to-back hits
    load_entry(32'h010, LD_W, 1'b0, 0, 1'b0);
    load_entry(32'h014, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h018, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h01C, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h084, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h08C, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h028, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h300, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h140, LD_W, 1'b0, 0, 1'b1);
    load_entry(32'h040, LD_W, 1'b0, 0, 1'b1);
  endtask

  // one entry per accepted edge, held while req_ready is low
  task automatic drive_requests();
    @(posedge clk);
    for (int i = 0; i < n_entries; i++) begin
      req_valid    <= 1'b1;
      req_addr     <= tab_addr[i];
      req_write    <= tab_write[i];
      req_type     <= tab_type[i];
      req_wdata    <= tab_wdata[i];
      req_strobe   <= tab_strobe[i];
      req_uncached <= tab_uncached[i];
      @(negedge clk);
      while (!req_ready) @(negedge clk);
      @(posedge clk);
    end
    req_valid <= 1'b0;
  endtask

  // read results arrive in request order
  always @(negedge clk) begin : response_monitor
    int k;
    if (rst_n && rvalid === 1'b1) begin
      if (resp_cnt >= n_reads) begin
        $display("read response seen with no read outstanding at cycle %0d", cycle_cnt);
        $display("SIMULATION FAILED");
        $fatal(1, "unexpected read response");
      end else begin
        k = read_idx[resp_cnt];
        check_value($sformatf("rdata_o (entry %0d)", k), rdata, tab_rdata[k]);
        check_value("wb read count increase", read_cnt - last_read_cnt, tab_reads[k]);
        if (tab_burst[k]) begin
          check_value("rvalid_o cycle", cycle_cnt, last_resp_cycle + 1);
        end
        last_resp_cycle <= cycle_cnt;
        last_read_cnt   <= read_cnt;
        resp_cnt        <= resp_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout after %0d cycles with %0d of %0d read results returned",
               cycle_cnt, resp_cnt, n_reads);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_write    = 1'b0;
    req_type     = LD_W;
    req_wdata    = '0;
    req_strobe   = '0;
    req_uncached = 1'b0;
    init_reference();
    build_table();
    timeout_limit = n_entries * CYC_PER_ENTRY + SET_CNT + 2;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    drive_requests();
    while (resp_cnt < n_reads) @(posedge clk);
    repeat (4) @(posedge clk);  // room for a stray response
    check_value("wb read count", read_cnt, reads_so_far);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/wb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
  parameter int DEPTH     = 1024,  // words
  parameter int ACK_DELAY = 2
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire         wb_we_i,
  input  wire [31:0]  wb_adr_i,
  input  wire [31:0]  wb_dat_i,
  input  wire [3:0]   wb_sel_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic [31:0] read_cnt_o
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [31:0]      mem [DEPTH];
  logic [IDX_W-1:0] idx;
  int unsigned      wait_cnt;

  assign idx = wb_adr_i[IDX_W+1:2];

  // word at byte address A holds A xor a5a50000
  initial begin
    wb_ack_o   = 1'b0;
    wb_dat_o   = '0;
    read_cnt_o = '0;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = (32'(i) << 2) ^ 32'hA5A5_0000;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      wb_ack_o   <= 1'b0;
      wb_dat_o   <= '0;
      read_cnt_o <= '0;
      wait_cnt   <= 0;
    end else if (wb_ack_o) begin
      wb_ack_o <= 1'b0;  // master drops cyc and stb on this edge
      wait_cnt <= 0;
    end else if (wb_cyc_i && wb_stb_i) begin
      if (wait_cnt == ACK_DELAY - 1) begin
        wb_ack_o <= 1'b1;
        wait_cnt <= 0;
        if (wb_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (wb_sel_i[b]) mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
          end
        end else begin
          wb_dat_o   <= mem[idx];
          read_cnt_o <= read_cnt_o + 1;  // counts completed reads
        end
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  // core side
  input  wire          req_valid_i,
  output wire          req_ready_o,
  input  wire addr_t   req_addr_i,
  input  wire          req_write_i,
  input  wire ld_type_e req_type_i,
  input  wire word_t   req_wdata_i,
  input  wire strobe_t req_strobe_i,
  input  wire          req_uncached_i,
  output wire [31:0]   rdata_o,
  output wire          rvalid_o,
  // wishbone
  output wire          wb_cyc_o,
  output wire          wb_stb_o,
  output wire          wb_we_o,
  output wire [31:0]   wb_adr_o,
  output wire [31:0]   wb_dat_o,
  output wire [3:0]    wb_sel_o,
  input  wire word_t   wb_dat_i,
  input  wire          wb_ack_i
);

  word_t [WAY_CNT-1:0]      way_rdata;
  tag_entry_t [WAY_CNT-1:0] way_tag;
  dram_addr_t               ram_raddr;
  set_idx_t                 tag_raddr;
  strobe_t [WAY_CNT-1:0]    data_we;
  dram_addr_t               data_waddr;
  word_t                    data_wdata;
  logic [WAY_CNT-1:0]       tag_we;
  set_idx_t                 tag_waddr;
  tag_entry_t               tag_wdata;
  logic                     refill_start;
  logic                     uncached_start;
  logic                     write_start;
  addr_t                    op_addr;
  word_t                    op_wdata;
  strobe_t                  op_strobe;
  logic [WAY_CNT-1:0]       hit_wsel;
  logic                     op_done;
  word_t                    fill_word;
  logic                     fill_valid;
  logic                     xfer_req;
  logic                     xfer_we;
  addr_t                    xfer_addr;
  word_t                    xfer_wdata;
  strobe_t                  xfer_sel;
  logic                     xfer_done;
  word_t                    xfer_rdata;

  // one data RAM and one tag RAM per way
  for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
    dcache_ram #(
      .DATA_W ($bits(word_t)),
      .DEPTH  (SET_CNT * LINE_WORDS),
      .WE_W   (4)
    ) u_data_ram (
      .clk     (clk),
      .waddr_i (data_waddr),
      .we_i    (data_we[w]),
      .wdata_i (data_wdata),
      .raddr_i (ram_raddr),
      .rdata_o (way_rdata[w])
    );

    dcache_ram #(
      .DATA_W ($bits(tag_entry_t)),
      .DEPTH  (SET_CNT),
      .WE_W   (1)
    ) u_tag_ram (
      .clk     (clk),
      .waddr_i (tag_waddr),
      .we_i    (tag_we[w]),
      .wdata_i (tag_wdata),
      .raddr_i (tag_raddr),
      .rdata_o (way_tag[w])
    );
  end

  dcache_rport u_rport (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_addr_i       (req_addr_i),
    .req_write_i      (req_write_i),
    .req_type_i       (req_type_i),
    .req_wdata_i      (req_wdata_i),
    .req_strobe_i     (req_strobe_i),
    .req_uncached_i   (req_uncached_i),
    .rdata_o          (rdata_o),
    .rvalid_o         (rvalid_o),
    .ram_raddr_o      (ram_raddr),
    .tag_raddr_o      (tag_raddr),
    .way_rdata_i      (way_rdata),
    .way_tag_i        (way_tag),
    .data_we_i        (data_we),
    .data_waddr_i     (data_waddr),
    .data_wdata_i     (data_wdata),
    .tag_we_i         (tag_we),
    .tag_waddr_i      (tag_waddr),
    .tag_wdata_i      (tag_wdata),
    .refill_start_o   (refill_start),
    .uncached_start_o (uncached_start),
    .write_start_o    (write_start),
    .op_addr_o        (op_addr),
    .op_wdata_o       (op_wdata),
    .op_strobe_o      (op_strobe),
    .hit_wsel_o       (hit_wsel),
    .op_done_i        (op_done),
    .fill_word_i      (fill_word),
    .fill_valid_i     (fill_valid)
  );

  dcache_wport u_wport (
    .clk              (clk),
    .rst_n            (rst_n),
    .refill_start_i   (refill_start),
    .uncached_start_i (uncached_start),
    .write_start_i    (write_start),
    .op_addr_i        (op_addr),
    .op_wdata_i       (op_wdata),
    .op_strobe_i      (op_strobe),
    .hit_wsel_i       (hit_wsel),
    .op_done_o        (op_done),
    .fill_word_o      (fill_word),
    .fill_valid_o     (fill_valid),
    .data_we_o        (data_we),
    .data_waddr_o     (data_waddr),
    .data_wdata_o     (data_wdata),
    .tag_we_o         (tag_we),
    .tag_waddr_o      (tag_waddr),
    .tag_wdata_o      (tag_wdata),
    .xfer_req_o       (xfer_req),
    .xfer_we_o        (xfer_we),
    .xfer_addr_o      (xfer_addr),
    .xfer_wdata_o     (xfer_wdata),
    .xfer_sel_o       (xfer_sel),
    .xfer_done_i      (xfer_done),
    .xfer_rdata_i     (xfer_rdata)
  );

  dcache_wb_master u_wb_master (
    .clk          (clk),
    .rst_n        (rst_n),
    .xfer_req_i   (xfer_req),
    .xfer_we_i    (xfer_we),
    .xfer_addr_i  (xfer_addr),
    .xfer_wdata_i (xfer_wdata),
    .xfer_sel_i   (xfer_sel),
    .xfer_done_o  (xfer_done),
    .xfer_rdata_o (xfer_rdata),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_o     (wb_dat_o),
    .wb_sel_o     (wb_sel_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i)
  );

endmodule

`default_nettype wire

//--- rtl/dcache_wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_wb_master
  import dcache_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  input  wire          xfer_req_i,
  input  wire          xfer_we_i,
  input  wire addr_t   xfer_addr_i,
  input  wire word_t   xfer_wdata_i,
  input  wire strobe_t xfer_sel_i,
  output logic         xfer_done_o,
  output logic [31:0]  xfer_rdata_o,
  // wishbone classic
  output logic         wb_cyc_o,
  output logic         wb_stb_o,
  output logic         wb_we_o,
  output logic [31:0]  wb_adr_o,
  output logic [31:0]  wb_dat_o,
  output logic [3:0]   wb_sel_o,
  input  wire word_t   wb_dat_i,
  input  wire          wb_ack_i
);

  logic start;
  logic ack;

  assign start = xfer_req_i && !wb_cyc_o;  // no new cycle while one is open
  assign ack   = wb_cyc_o && wb_ack_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_cyc_o    <= 1'b0;
      wb_stb_o    <= 1'b0;
      xfer_done_o <= 1'b0;
    end else begin
      xfer_done_o <= ack;
      if (ack) begin
        wb_cyc_o <= 1'b0;
        wb_stb_o <= 1'b0;
      end else if (start) begin
        wb_cyc_o <= 1'b1;
        wb_stb_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      wb_we_o  <= xfer_we_i;
      wb_adr_o <= xfer_addr_i;
      wb_dat_o <= xfer_wdata_i;
      wb_sel_o <= xfer_sel_i;
    end
    if (ack) xfer_rdata_o <= wb_dat_i;  // read data lands with the ack
  end

endmodule

`default_nettype wire

//--- rtl/dcache_wport.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_wport
  import dcache_pkg::*;
(
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         refill_start_i,
  input  wire                         uncached_start_i,
  input  wire                         write_start_i,
  input  wire addr_t                  op_addr_i,
  input  wire word_t                  op_wdata_i,
  input  wire strobe_t                op_strobe_i,
  input  wire [WAY_CNT-1:0]           hit_wsel_i,
  output logic                        op_done_o,
  output logic [31:0]                 fill_word_o,
  output logic                        fill_valid_o,
  // RAM write side
  output strobe_t [WAY_CNT-1:0]       data_we_o,
  output logic [5:0]                  data_waddr_o,
  output logic [31:0]                 data_wdata_o,
  output logic [WAY_CNT-1:0]          tag_we_o,
  output logic [3:0]                  tag_waddr_o,
  output logic [TAG_W:0]              tag_wdata_o,
  // bus master
  output logic                        xfer_req_o,
  output logic                        xfer_we_o,
  output logic [31:0]                 xfer_addr_o,
  output logic [31:0]                 xfer_wdata_o,
  output logic [3:0]                  xfer_sel_o,
  input  wire                         xfer_done_i,
  input  wire word_t                  xfer_rdata_i
);

  localparam int CNT_W = $clog2(LINE_WORDS);

  wport_state_e     state_q;
  logic [CNT_W-1:0] word_cnt_q;
  logic             last_word;
  logic             single_we_q;
  logic             victim_q;
  logic             sweep_q;
  set_idx_t         sweep_cnt_q;
  logic             req_q;

  assign last_word = (word_cnt_q == CNT_W'(LINE_WORDS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= W_IDLE;
      word_cnt_q  <= '0;
      victim_q    <= 1'b0;
      req_q       <= 1'b0;
      sweep_q     <= 1'b1;  // invalidate all tags out of reset
      sweep_cnt_q <= '0;
    end else begin
      req_q <= 1'b0;
      if (sweep_q) begin
        sweep_cnt_q <= sweep_cnt_q + 1'b1;
        if (sweep_cnt_q == set_idx_t'(SET_CNT - 1)) begin
          sweep_q <= 1'b0;
        end
      end
      case (state_q)
        W_IDLE: begin
          if (refill_start_i) begin
            state_q <= W_REFILL;
            req_q   <= 1'b1;
          end else if (uncached_start_i || write_start_i) begin
            state_q <= W_SINGLE;
            req_q   <= 1'b1;
          end
        end
        W_REFILL: begin
          if (xfer_done_i) begin
            word_cnt_q <= word_cnt_q + 1'b1;
            if (last_word) begin
              state_q  <= W_DONE;
              victim_q <= ~victim_q;
            end else begin
              req_q <= 1'b1;  // next word of the line
            end
          end
        end
        W_SINGLE: if (xfer_done_i) state_q <= W_DONE;
        default:  state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == W_IDLE) begin
      single_we_q <= write_start_i;
    end
  end

  assign op_done_o    = (state_q == W_DONE);
  assign fill_word_o  = xfer_rdata_i;
  assign fill_valid_o = xfer_done_i &&
                        ((state_q == W_REFILL && word_cnt_q == op_addr_i[3:2]) ||
                         (state_q == W_SINGLE && !single_we_q));

  // bus request, refills walk the line from word 0
  assign xfer_req_o   = req_q;
  assign xfer_we_o    = (state_q == W_SINGLE) && single_we_q;
  assign xfer_addr_o  = (state_q == W_REFILL) ? {op_addr_i[31:4], word_cnt_q, 2'b00}
                                              : {op_addr_i[31:2], 2'b00};
  assign xfer_wdata_o = op_wdata_i;
  assign xfer_sel_o   = xfer_we_o ? op_strobe_i : 4'hf;

  always_comb begin
    data_we_o = '0;
    tag_we_o  = '0;
    if (write_start_i) begin  // store hit updates the line right away
      for (int w = 0; w < WAY_CNT; w++) begin
        if (hit_wsel_i[w]) data_we_o[w] = op_strobe_i;
      end
    end
    if (state_q == W_REFILL && xfer_done_i) begin
      data_we_o[victim_q] = '1;
      tag_we_o[victim_q]  = last_word;
    end
    if (sweep_q) tag_we_o = '1;
  end

  assign data_waddr_o = (state_q == W_REFILL) ? {addr_set(op_addr_i), word_cnt_q}
                                              : addr_dram(op_addr_i);
  assign data_wdata_o = (state_q == W_REFILL) ? xfer_rdata_i : op_wdata_i;
  assign tag_waddr_o  = sweep_q ? sweep_cnt_q : addr_set(op_addr_i);
  assign tag_wdata_o  = sweep_q ? '0 : {1'b1, addr_tag(op_addr_i)};

endmodule

`default_nettype wire

//--- rtl/dcache_rport.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_rport
  import dcache_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst_n,
  // core request
  input  wire                        req_valid_i,
  output logic                       req_ready_o,
  input  wire addr_t                 req_addr_i,
  input  wire                        req_write_i,
  input  wire ld_type_e              req_type_i,
  input  wire word_t                 req_wdata_i,
  input  wire strobe_t               req_strobe_i,
  input  wire                        req_uncached_i,
  output logic [31:0]                rdata_o,
  output logic                       rvalid_o,
  // RAM read side
  output logic [5:0]                 ram_raddr_o,
  output logic [3:0]                 tag_raddr_o,
  input  wire word_t [WAY_CNT-1:0]   way_rdata_i,
  input  wire tag_entry_t [WAY_CNT-1:0] way_tag_i,
  // RAM write side, snooped for forwarding
  input  wire strobe_t [WAY_CNT-1:0] data_we_i,
  input  wire dram_addr_t            data_waddr_i,
  input  wire word_t                 data_wdata_i,
  input  wire [WAY_CNT-1:0]          tag_we_i,
  input  wire set_idx_t              tag_waddr_i,
  input  wire tag_entry_t            tag_wdata_i,
  // write port handshake
  output logic                       refill_start_o,
  output logic                       uncached_start_o,
  output logic                       write_start_o,
  output logic [31:0]                op_addr_o,
  output logic [31:0]                op_wdata_o,
  output logic [3:0]                 op_strobe_o,
  output logic [WAY_CNT-1:0]         hit_wsel_o,
  input  wire                        op_done_i,
  input  wire word_t                 fill_word_i,
  input  wire                        fill_valid_i
);

  rport_state_e fsm_q, fsm_d;
  logic         fsm_busy;
  logic         sweep;
  logic         busy;
  logic         ex_fire;

  // M1 stage
  logic         m1_valid_q;
  addr_t        m1_addr_q;
  logic         m1_write_q;
  ld_type_e     m1_type_q;
  word_t        m1_wdata_q;
  strobe_t      m1_strobe_q;
  logic         m1_uncached_q;
  word_t [WAY_CNT-1:0]      m1_rdata;
  tag_entry_t [WAY_CNT-1:0] m1_tag;
  logic [WAY_CNT-1:0]       m1_hit;
  word_t        m1_word;

  // previous-cycle RAM writes
  strobe_t [WAY_CNT-1:0] data_we_q;
  dram_addr_t   data_waddr_q;
  word_t        data_wdata_q;
  logic [WAY_CNT-1:0] tag_we_q;
  set_idx_t     tag_waddr_q;
  tag_entry_t   tag_wdata_q;

  // M2 stage
  logic         m2_valid_q;
  addr_t        m2_addr_q;
  logic         m2_write_q;
  ld_type_e     m2_type_q;
  word_t        m2_wdata_q;
  strobe_t      m2_strobe_q;
  logic         m2_uncached_q;
  logic [WAY_CNT-1:0] m2_hit_q;
  word_t        m2_word_q;
  word_t        fill_q;
  word_t        m2_word;

  function automatic word_t fmt_load(word_t w, logic [1:0] off, ld_type_e t);
    word_t sh;
    sh = w >> {off, 3'b000};
    case (t)
      LD_B:    return {{24{sh[7]}}, sh[7:0]};
      LD_BU:   return {24'h0, sh[7:0]};
      LD_H:    return {{16{sh[15]}}, sh[15:0]};
      LD_HU:   return {16'h0, sh[15:0]};
      default: return w;
    endcase
  endfunction

  // only the reset sweep writes every tag way at once
  assign sweep       = &tag_we_i;
  assign busy        = fsm_busy || sweep;
  assign req_ready_o = !busy;
  assign ex_fire     = req_valid_i && req_ready_o;

  // M1 rereads its own line while stalled
  assign ram_raddr_o = addr_dram(busy ? m1_addr_q : req_addr_i);
  assign tag_raddr_o = addr_set(busy ? m1_addr_q : req_addr_i);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m1_valid_q <= 1'b0;
    end else if (!busy) begin
      m1_valid_q <= ex_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy) begin
      m1_addr_q     <= req_addr_i;
      m1_write_q    <= req_write_i;
      m1_type_q     <= req_type_i;
      m1_wdata_q    <= req_wdata_i;
      m1_strobe_q   <= req_strobe_i;
      m1_uncached_q <= req_uncached_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_we_q <= '0;
      tag_we_q  <= '0;
    end else begin
      data_we_q <= data_we_i;
      tag_we_q  <= tag_we_i;
    end
  end

  always_ff @(posedge clk) begin
    data_waddr_q <= data_waddr_i;
    data_wdata_q <= data_wdata_i;
    tag_waddr_q  <= tag_waddr_i;
    tag_wdata_q  <= tag_wdata_i;
  end

  // forward RAM writes, current cycle wins over previous
  always_comb begin
    m1_rdata = way_rdata_i;
    m1_tag   = way_tag_i;
    m1_word  = '0;
    for (int w = 0; w < WAY_CNT; w++) begin
      for (int b = 0; b < 4; b++) begin
        if (data_we_q[w][b] && data_waddr_q == addr_dram(m1_addr_q)) begin
          m1_rdata[w][8*b +: 8] = data_wdata_q[8*b +: 8];
        end
        if (data_we_i[w][b] && data_waddr_i == addr_dram(m1_addr_q)) begin
          m1_rdata[w][8*b +: 8] = data_wdata_i[8*b +: 8];
        end
      end
      if (tag_we_q[w] && tag_waddr_q == addr_set(m1_addr_q)) begin
        m1_tag[w] = tag_wdata_q;
      end
      if (tag_we_i[w] && tag_waddr_i == addr_set(m1_addr_q)) begin
        m1_tag[w] = tag_wdata_i;
      end
      m1_hit[w] = m1_tag[w][TAG_W] && !m1_uncached_q &&
                  (m1_tag[w][TAG_W-1:0] == addr_tag(m1_addr_q));
      m1_word  |= m1_hit[w] ? m1_rdata[w] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m2_valid_q <= 1'b0;
    end else if (!busy) begin
      m2_valid_q <= m1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy) begin
      m2_addr_q     <= m1_addr_q;
      m2_write_q    <= m1_write_q;
      m2_type_q     <= m1_type_q;
      m2_wdata_q    <= m1_wdata_q;
      m2_strobe_q   <= m1_strobe_q;
      m2_uncached_q <= m1_uncached_q;
      m2_hit_q      <= m1_hit;
      m2_word_q     <= m1_word;
    end
    if (fill_valid_i) begin
      fill_q <= fill_word_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm_q <= S_NORMAL;
    end else begin
      fsm_q <= fsm_d;
    end
  end

  always_comb begin
    fsm_d            = fsm_q;
    fsm_busy         = 1'b0;
    refill_start_o   = 1'b0;
    uncached_start_o = 1'b0;
    write_start_o    = 1'b0;
    case (fsm_q)
      S_NORMAL: begin
        if (m2_valid_q) begin
          if (m2_write_q) begin  // every store goes to memory
            write_start_o = 1'b1;
            fsm_d         = S_WRITE;
            fsm_busy      = 1'b1;
          end else if (m2_uncached_q) begin
            uncached_start_o = 1'b1;
            fsm_d            = S_UNCACHED_READ;
            fsm_busy         = 1'b1;
          end else if (!(|m2_hit_q)) begin
            refill_start_o = 1'b1;
            fsm_d          = S_REFILL;
            fsm_busy       = 1'b1;
          end
        end
      end
      default: begin
        if (op_done_i) begin
          fsm_d = S_NORMAL;  // retire this cycle
        end else begin
          fsm_busy = 1'b1;
        end
      end
    endcase
  end

  assign op_addr_o   = m2_addr_q;
  assign op_wdata_o  = m2_wdata_q;
  assign op_strobe_o = m2_strobe_q;
  assign hit_wsel_o  = write_start_o ? m2_hit_q : '0;

  // fill word after a refill or uncached read
  assign m2_word  = (fsm_q == S_NORMAL) ? m2_word_q : fill_q;
  assign rdata_o  = fmt_load(m2_word, m2_addr_q[1:0], m2_type_q);
  assign rvalid_o = m2_valid_q && !m2_write_q && !busy;

endmodule

`default_nettype wire

//--- rtl/dcache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ram #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 64,
  parameter int WE_W   = 4   // 4 for byte lanes, 1 for a whole-word write
) (
  input  wire                     clk,
  input  wire [$clog2(DEPTH)-1:0] waddr_i,
  input  wire [WE_W-1:0]          we_i,
  input  wire [DATA_W-1:0]        wdata_i,
  input  wire [$clog2(DEPTH)-1:0] raddr_i,
  output logic [DATA_W-1:0]       rdata_o
);

  localparam int LANE_W = DATA_W / WE_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // write side, one lane per enable bit
  always_ff @(posedge clk) begin
    for (int b = 0; b < WE_W; b++) begin
      if (we_i[b]) begin
        mem[waddr_i][b*LANE_W +: LANE_W] <= wdata_i[b*LANE_W +: LANE_W];
      end
    end
  end

  // registered read, returns old contents on a same-edge write
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // cache geometry
  localparam int WAY_CNT    = 2;
  localparam int SET_CNT    = 16;
  localparam int LINE_WORDS = 4;
  localparam int TAG_W      = 24;  // addr[31:8]

  typedef logic [31:0]      addr_t;
  typedef logic [31:0]      word_t;
  typedef logic [3:0]       strobe_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [TAG_W:0]   tag_entry_t;  // {valid, tag}
  typedef logic [3:0]       set_idx_t;
  typedef logic [5:0]       dram_addr_t;  // {set, word offset}

  typedef enum logic [2:0] {
    LD_B,
    LD_BU,
    LD_H,
    LD_HU,
    LD_W
  } ld_type_e;

  typedef enum logic [1:0] {
    S_NORMAL,
    S_REFILL,
    S_UNCACHED_READ,
    S_WRITE
  } rport_state_e;

  typedef enum logic [1:0] {
    W_IDLE,
    W_REFILL,
    W_SINGLE,
    W_DONE
  } wport_state_e;

  function automatic set_idx_t addr_set(addr_t a);
    return a[7:4];
  endfunction

  function automatic dram_addr_t addr_dram(addr_t a);
    return a[7:2];
  endfunction

  function automatic tag_t addr_tag(addr_t a);
    return a[31:8];
  endfunction

endpackage

`default_nettype wire
